//--- verilog/sd_rx_defines.svh
`ifndef SD_RX_DEFINES_SVH
`define SD_RX_DEFINES_SVH

// ----------------------------------------
// Receive FIFO geometry
// ----------------------------------------

// Words held by the receive FIFO, power of two
`define FIFO_RX_MEM_DEPTH 8

// Pointer width, log2 of depth plus one wrap bit
`define FIFO_RX_MEM_ADR_SIZE 4

// ----------------------------------------
// Block format on the DAT lines
// ----------------------------------------

// Data nibbles per block, multiple of 8
`define RX_BLOCK_NIBBLES 64

// CRC16 trailer, one bit per line per nibble
`define RX_CRC_NIBBLES 16

`endif

//--- verilog/sd_bus_pkg.sv
package sd_bus_pkg;

  // ----------------------------------------
  // Card side of the receive path
  // ----------------------------------------

  // One sample of DAT[3:0]
  typedef logic [3:0] nibble_t;

  // CRC16 register, x^16+x^12+x^5+1
  typedef logic [15:0] crc16_t;

  // One CRC register per DAT line, index is the line number
  typedef crc16_t [3:0] crc_lines_t;

endpackage

//--- verilog/sd_fifo_pkg.sv
`include "sd_rx_defines.svh"

package sd_fifo_pkg;

  // Packed receive word, first nibble in bits 3:0
  typedef logic [31:0] word_t;

  // Words held, wide enough to count a full FIFO
  typedef logic [`FIFO_RX_MEM_ADR_SIZE-1:0] fill_t;

endpackage

//--- verilog/sd_rx_packer.sv
module sd_rx_packer (
  input  logic                wclk,
  input  logic                rst,
  input  logic                clr_i,
  input  logic                data_stb_i,
  input  sd_bus_pkg::nibble_t dat_i,
  output sd_fifo_pkg::word_t  word_o,
  output logic                word_stb_o
);

  localparam int LANES = 8;

  logic [LANES-1:0]   lane_sel;
  sd_fifo_pkg::word_t hold_q;
  logic               word_stb_q;

  // One-hot lane select, lane 0 takes the first nibble
  always_ff @(posedge wclk or posedge rst) begin
    if (rst) begin
      lane_sel <= LANES'(1);
    end else if (clr_i) begin
      lane_sel <= LANES'(1);
    end else if (data_stb_i) begin
      lane_sel <= {lane_sel[LANES-2:0], lane_sel[LANES-1]};
    end
  end

  // Holding register
  always_ff @(posedge wclk) begin
    for (int i = 0; i < LANES; i++) begin
      if (data_stb_i && lane_sel[i]) begin
        hold_q[4*i +: 4] <= dat_i;
      end
    end
  end

  // Word complete once the top lane is loaded
  always_ff @(posedge wclk or posedge rst) begin
    if (rst) begin
      word_stb_q <= 1'b0;
    end else begin
      word_stb_q <= data_stb_i && lane_sel[LANES-1] && !clr_i;
    end
  end

  assign word_o     = hold_q;
  assign word_stb_o = word_stb_q;

endmodule

//--- verilog/sd_rx_crc16.sv
module sd_rx_crc16 (
  input  logic                wclk,
  input  logic                rst,
  input  logic                clr_i,
  input  logic                data_stb_i,
  input  logic                crc_stb_i,
  input  sd_bus_pkg::nibble_t dat_i,
  output logic                crc_err_o
);

  localparam sd_bus_pkg::crc16_t POLY = 16'h1021;

  sd_bus_pkg::crc_lines_t crc_q;
  logic [3:0]             crc_msb;
  logic                   crc_err_q;

  // One serial CRC16 step, MSB first
  function automatic sd_bus_pkg::crc16_t crc16_step(
    input sd_bus_pkg::crc16_t crc,
    input logic               bit_in
  );
    logic fb;
    fb = bit_in ^ crc[15];
    return {crc[14:0], 1'b0} ^ (fb ? POLY : 16'h0000);
  endfunction

  // Expected CRC bit of each line
  always_comb begin
    for (int l = 0; l < 4; l++) begin
      crc_msb[l] = crc_q[l][15];
    end
  end

  // ----------------------------------------
  // Per-line generators and compare
  // ----------------------------------------
  always_ff @(posedge wclk or posedge rst) begin
    if (rst) begin
      crc_q     <= '0;
      crc_err_q <= 1'b0;
    end else if (clr_i) begin
      crc_q     <= '0;
      crc_err_q <= 1'b0;
    end else if (data_stb_i) begin
      for (int l = 0; l < 4; l++) begin
        crc_q[l] <= crc16_step(crc_q[l], dat_i[l]);
      end
    end else if (crc_stb_i) begin
      // Trailer phase, shift the computed CRC out against the received bits
      for (int l = 0; l < 4; l++) begin
        crc_q[l] <= {crc_q[l][14:0], 1'b0};
      end
      if (crc_msb != dat_i) begin
        crc_err_q <= 1'b1;
      end
    end
  end

  // Sticky until the next block start
  assign crc_err_o = crc_err_q;

endmodule

//--- verilog/sd_rx_block_ctrl.sv
`include "sd_rx_defines.svh"

module sd_rx_block_ctrl (
  input  logic wclk,
  input  logic rst,
  input  logic blk_start_i,
  input  logic dat_valid_i,
  input  logic overrun_i,
  input  logic crc_err_i,
  output logic data_stb_o,
  output logic crc_stb_o,
  output logic clr_o,
  output logic blk_done_o,
  output logic crc_err_o,
  output logic overrun_o
);

  localparam int CNT_W = $clog2(`RX_BLOCK_NIBBLES);

  typedef enum logic [1:0] {
    PH_IDLE,
    PH_DATA,
    PH_CRC
  } phase_e;

  phase_e           phase_q;
  logic [CNT_W-1:0] cnt_q;
  logic             done_q;
  logic             status_vld_q;

  // Strobe routing by phase
  assign data_stb_o = dat_valid_i && (phase_q == PH_DATA);
  assign crc_stb_o  = dat_valid_i && (phase_q == PH_CRC);
  assign clr_o      = blk_start_i;

  // ----------------------------------------
  // Phase and nibble count
  // ----------------------------------------
  always_ff @(posedge wclk or posedge rst) begin
    if (rst) begin
      phase_q      <= PH_IDLE;
      cnt_q        <= '0;
      done_q       <= 1'b0;
      status_vld_q <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (blk_start_i) begin
        phase_q      <= PH_DATA;
        cnt_q        <= '0;
        status_vld_q <= 1'b0;
      end else if (data_stb_o) begin
        if (cnt_q == CNT_W'(`RX_BLOCK_NIBBLES - 1)) begin
          phase_q <= PH_CRC;
          cnt_q   <= '0;
        end else begin
          cnt_q <= cnt_q + 1'b1;
        end
      end else if (crc_stb_o) begin
        if (cnt_q == CNT_W'(`RX_CRC_NIBBLES - 1)) begin
          phase_q      <= PH_IDLE;
          cnt_q        <= '0;
          done_q       <= 1'b1;
          status_vld_q <= 1'b1;
        end else begin
          cnt_q <= cnt_q + 1'b1;
        end
      end
    end
  end

  // Both sources are sticky and frozen once the block ends
  assign blk_done_o = done_q;
  assign crc_err_o  = status_vld_q && crc_err_i;
  assign overrun_o  = status_vld_q && overrun_i;

endmodule

//--- verilog/sd_rx_fifo.sv
`include "sd_rx_defines.svh"

module sd_rx_fifo (
  input  logic               wclk,
  input  logic               rst,
  input  logic               clr_i,
  input  logic               wr_i,
  input  sd_fifo_pkg::word_t din_i,
  input  logic               rd_i,
  output sd_fifo_pkg::word_t q_o,
  output logic               full_o,
  output logic               empty_o,
  output sd_fifo_pkg::fill_t fill_o,
  output logic               overrun_o
);

  localparam int PW = `FIFO_RX_MEM_ADR_SIZE;

  sd_fifo_pkg::word_t ram [0:`FIFO_RX_MEM_DEPTH-1];
  logic [PW-1:0]      wr_ptr;
  logic [PW-1:0]      rd_ptr;
  logic               ram_we;
  logic               ram_re;
  logic               overrun_q;

  // Top pointer bit is the wrap flag
  assign full_o  = (wr_ptr[PW-2:0] == rd_ptr[PW-2:0]) && (wr_ptr[PW-1] != rd_ptr[PW-1]);
  assign empty_o = (wr_ptr == rd_ptr);
  assign fill_o  = wr_ptr - rd_ptr;

  assign ram_we = wr_i && !full_o;
  assign ram_re = rd_i && !empty_o;

  always_ff @(posedge wclk) begin
    if (ram_we) begin
      ram[wr_ptr[PW-2:0]] <= din_i;
    end
  end

  // Oldest word, valid while not empty
  assign q_o = ram[rd_ptr[PW-2:0]];

  // ----------------------------------------
  // Pointers and overrun flag
  // ----------------------------------------
  always_ff @(posedge wclk or posedge rst) begin
    if (rst) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      overrun_q <= 1'b0;
    end else begin
      if (ram_we) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (ram_re) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Card cannot be stalled, a word arriving at full is lost
      if (clr_i) begin
        overrun_q <= 1'b0;
      end else if (wr_i && full_o) begin
        overrun_q <= 1'b1;
      end
    end
  end

  assign overrun_o = overrun_q;

endmodule

//--- verilog/sd_rx_path.sv
module sd_rx_path (
  input  logic                wclk,
  input  logic                rst,
  input  logic                blk_start_i,
  input  sd_bus_pkg::nibble_t dat_i,
  input  logic                dat_valid_i,
  input  logic                rd_i,
  output sd_fifo_pkg::word_t  q_o,
  output logic                empty_o,
  output logic                full_o,
  output sd_fifo_pkg::fill_t  fill_o,
  output logic                blk_done_o,
  output logic                crc_err_o,
  output logic                overrun_o
);

  logic               data_stb;
  logic               crc_stb;
  logic               clr;
  sd_fifo_pkg::word_t word;
  logic               word_stb;
  logic               crc_err;
  logic               overrun;

  // ----------------------------------------
  // Block sequencing
  // ----------------------------------------
  sd_rx_block_ctrl u_block_ctrl (
    .wclk        (wclk),
    .rst         (rst),
    .blk_start_i (blk_start_i),
    .dat_valid_i (dat_valid_i),
    .overrun_i   (overrun),
    .crc_err_i   (crc_err),
    .data_stb_o  (data_stb),
    .crc_stb_o   (crc_stb),
    .clr_o       (clr),
    .blk_done_o  (blk_done_o),
    .crc_err_o   (crc_err_o),
    .overrun_o   (overrun_o)
  );

  // Packer and CRC checker see the same nibble stream
  sd_rx_packer u_packer (
    .wclk       (wclk),
    .rst        (rst),
    .clr_i      (clr),
    .data_stb_i (data_stb),
    .dat_i      (dat_i),
    .word_o     (word),
    .word_stb_o (word_stb)
  );

  sd_rx_crc16 u_crc16 (
    .wclk       (wclk),
    .rst        (rst),
    .clr_i      (clr),
    .data_stb_i (data_stb),
    .crc_stb_i  (crc_stb),
    .dat_i      (dat_i),
    .crc_err_o  (crc_err)
  );

  // Host side buffer
  sd_rx_fifo u_fifo (
    .wclk      (wclk),
    .rst       (rst),
    .clr_i     (clr),
    .wr_i      (word_stb),
    .din_i     (word),
    .rd_i      (rd_i),
    .q_o       (q_o),
    .full_o    (full_o),
    .empty_o   (empty_o),
    .fill_o    (fill_o),
    .overrun_o (overrun)
  );

endmodule

//--- testbench/sd_rx_path_assertions.sv
`include "sd_rx_defines.svh"

module sd_rx_path_assertions (
  input logic               wclk,
  input logic               rst,
  input logic               full_o,
  input logic               empty_o,
  input sd_fifo_pkg::fill_t fill_o
);
  timeunit 1ns;
  timeprecision 100ps;

  int fails = 0;

  // Full and empty exclude each other
  full_empty_excl: assert property (@(posedge wclk) disable iff (rst) !(full_o && empty_o))
    else begin
      $error("FIFO reports full and empty at once");
      fails++;
    end

  fill_in_range: assert property (@(posedge wclk) disable iff (rst)
    fill_o <= sd_fifo_pkg::fill_t'(`FIFO_RX_MEM_DEPTH))
    else begin
      $error("FIFO fill level %0d above depth", fill_o);
      fails++;
    end

endmodule

bind sd_rx_fifo sd_rx_path_assertions u_fifo_checks (
  .wclk    (wclk),
  .rst     (rst),
  .full_o  (full_o),
  .empty_o (empty_o),
  .fill_o  (fill_o)
);

//--- testbench/sd_rx_path_tb.sv
`include "sd_rx_defines.svh"

module sd_rx_path_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int DEPTH = `FIFO_RX_MEM_DEPTH;
  localparam int NIBS  = `RX_BLOCK_NIBBLES;
  // Host behavior per block
  localparam int RD_DURING = 0;
  localparam int RD_AFTER  = 1;
  localparam int RD_HOLD   = 2;

  typedef struct packed {
    int rnd;      // 1 for random data and 0 for a counting pattern
    int corrupt;  // CRC nibble to flip or -1 for none
    int gap;      // idle cycles between nibbles or -1 for random 0..3
    int mode;
  } row_t;

  logic                wclk        = 1'b0;
  logic                rst         = 1'b1;
  logic                blk_start_i = 1'b0;
  sd_bus_pkg::nibble_t dat_i       = '0;
  logic                dat_valid_i = 1'b0;
  logic                rd_i        = 1'b0;
  sd_fifo_pkg::word_t  q_o;
  sd_fifo_pkg::fill_t  fill_o;
  logic                empty_o;
  logic                full_o;
  logic                blk_done_o;
  logic                crc_err_o;
  logic                overrun_o;

  row_t                rows [8];
  sd_bus_pkg::nibble_t nibs [NIBS];
  sd_fifo_pkg::word_t  exp_q [$];
  int                  seed        = 32'hcdf5d7de;
  int                  errs        = 0;
  int                  rows_failed = 0;
  logic                read_en     = 1'b0;
  logic                exp_ovr     = 1'b0;

  always #4 wclk = ~wclk;

  sd_rx_path u_sd_rx_path (.*);

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      errs++;
    end
  endtask

  // Host read checks the oldest expected word at q_o
  task automatic service_read();
    rd_i = 1'b0;
    if (read_en && !empty_o) begin
      assert (exp_q.size() > 0) else begin
        $display("FIFO holds a word at %0t ns that was never sent", $time);
        errs++;
      end
      if (exp_q.size() > 0) begin
        check_value("q_o", q_o, exp_q.pop_front());
      end
      rd_i = 1'b1;
    end
  endtask

  // Sample after the edge and release the strobes
  task automatic next_cycle();
    @(posedge wclk);
    #1;
    service_read();
    blk_start_i = 1'b0;
    dat_valid_i = 1'b0;
  endtask

  task automatic send_nibble(input sd_bus_pkg::nibble_t n, input int gap);
    int g;
    g = (gap < 0) ? int'({$random(seed)} % 4) : gap;
    repeat (g) next_cycle();
    next_cycle();
    dat_i       = n;
    dat_valid_i = 1'b1;
  endtask

  // CRC16 x^16+x^12+x^5+1 of one DAT line with zero start and MSB first
  function automatic sd_bus_pkg::crc16_t line_crc(input int line);
    sd_bus_pkg::crc16_t c;
    logic               fb;
    c = '0;
    for (int i = 0; i < NIBS; i++) begin
      fb = c[15] ^ nibs[i][line];
      c  = {c[14:0], 1'b0};
      if (fb) begin
        c = c ^ 16'h1021;
      end
    end
    return c;
  endfunction

  // ----------------------------------------
  // One block of the table
  // ----------------------------------------
  task automatic run_row(input int r);
    sd_bus_pkg::crc16_t  crc [4];
    sd_fifo_pkg::word_t  w;
    sd_bus_pkg::nibble_t n;
    int                  cnt;
    int                  errs_before;
    errs_before = errs;
    exp_ovr     = 1'b0;
    read_en     = (rows[r].mode == RD_DURING);
    for (int i = 0; i < NIBS; i++) begin
      nibs[i] = (rows[r].rnd != 0) ? 4'($random(seed)) : 4'(i);
    end
    for (int l = 0; l < 4; l++) begin
      crc[l] = line_crc(l);
    end
    next_cycle();
    blk_start_i = 1'b1;
    w           = '0;
    for (int i = 0; i < NIBS; i++) begin
      send_nibble(nibs[i], (i == 0) ? 0 : rows[r].gap);
      w[4*(i%8) +: 4] = nibs[i];
      // Complete little-endian word is dropped when the FIFO is full
      if (i % 8 == 7) begin
        if (exp_q.size() >= DEPTH) begin
          exp_ovr = 1'b1;
        end else begin
          exp_q.push_back(w);
        end
      end
    end
    for (int k = 0; k < 16; k++) begin
      n = {crc[3][15-k], crc[2][15-k], crc[1][15-k], crc[0][15-k]};
      send_nibble((k == rows[r].corrupt) ? ~n : n, rows[r].gap);
    end
    cnt = 0;
    do begin
      next_cycle();
      cnt++;
    end while (!blk_done_o && cnt < 10);
    assert (blk_done_o && cnt == 1) else begin
      $display("Row %0d: blk_done_o not seen one cycle after the last CRC nibble", r);
      errs++;
    end
    check_value("crc_err_o", 32'(crc_err_o), 32'(rows[r].corrupt >= 0));
    check_value("overrun_o", 32'(overrun_o), 32'(exp_ovr));
    if (rows[r].mode != RD_DURING) begin
      check_value("full_o", 32'(full_o), 32'(exp_q.size() == DEPTH));
      check_value("fill_o", 32'(fill_o), 32'(exp_q.size()));
    end
    if (rows[r].mode != RD_HOLD) begin
      read_en = 1'b1;
      cnt     = 0;
      while (exp_q.size() > 0 && cnt < 4 * DEPTH) begin
        next_cycle();
        cnt++;
      end
      read_en = 1'b0;
      next_cycle();
      assert (exp_q.size() == 0) else begin
        $display("Row %0d: FIFO ran dry with %0d words still missing", r, exp_q.size());
        errs++;
      end
      // Reads of an empty FIFO are ignored
      repeat (3) begin
        rd_i = 1'b1;
        next_cycle();
        check_value("empty_o", 32'(empty_o), 32'd1);
        check_value("fill_o", 32'(fill_o), 32'd0);
      end
    end
    if (errs == errs_before) begin
      $display("Row %0d ok", r);
    end else begin
      rows_failed++;
      $display("Row %0d: %0d errors", r, errs - errs_before);
    end
  endtask

  initial begin
    rows[0] = '{1, -1, 0, RD_DURING};
    rows[1] = '{0, 3, 1, RD_DURING};
    rows[2] = '{1, -1, -1, RD_DURING};
    rows[3] = '{1, 15, -1, RD_DURING};
    rows[4] = '{1, -1, 0, RD_AFTER};
    rows[5] = '{1, -1, 0, RD_HOLD};
    rows[6] = '{1, 0, 2, RD_AFTER};
    rows[7] = '{1, -1, -1, RD_DURING};
    repeat (3) @(posedge wclk);
    #1;
    rst = 1'b0;
    next_cycle();
    check_value("empty_o", 32'(empty_o), 32'd1);
    check_value("fill_o", 32'(fill_o), 32'd0);
    check_value("full_o", 32'(full_o), 32'd0);
    check_value("blk_done_o", 32'(blk_done_o), 32'd0);
    check_value("crc_err_o", 32'(crc_err_o), 32'd0);
    check_value("overrun_o", 32'(overrun_o), 32'd0);
    $display("Reset state: %0d errors", errs);
    for (int r = 0; r < 8; r++) begin
      run_row(r);
    end
    $display("Rows passed: %0d, rows failed: %0d", 8 - rows_failed, rows_failed);
    if (errs == 0 && u_sd_rx_path.u_fifo.u_fifo_checks.fails == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- tb.f
+incdir+verilog
verilog/sd_bus_pkg.sv
verilog/sd_fifo_pkg.sv
verilog/sd_rx_packer.sv
verilog/sd_rx_crc16.sv
verilog/sd_rx_block_ctrl.sv
verilog/sd_rx_fifo.sv
verilog/sd_rx_path.sv
testbench/sd_rx_path_assertions.sv
testbench/sd_rx_path_tb.sv

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f tb.f --top-module sd_rx_path_tb \
  && ./obj_dir/Vsd_rx_path_tb | tee /dev/stderr | grep -q "Simulation passed" \
  && echo "run.sh: testbench reported success" \
  || { echo "run.sh: build or simulation failure"; exit 1; }
